// File: rx_frontend.f
common/rx_frontend_pkg.sv
verilog/rx_settings.sv
verilog/iq_mapper.sv
iq_correction/dc_offset_corr.sv
iq_correction/iq_imbalance_comp.sv
verilog/rx_output_stage.sv
verilog/rx_frontend.sv
+incdir+verification
verification/rx_frontend_tb.sv

// File: verification/rx_frontend_model.svh
// Reference model of the front end: rail mapping, DC offset, imbalance correction and rounding
`ifndef RX_FRONTEND_MODEL_SVH
`define RX_FRONTEND_MODEL_SVH

// Saturate to the signed range of the given width
function automatic longint clamp_signed(input longint x, input int width);
  longint hi;
  hi = (64'sd1 <<< (width - 1)) - 1;
  return (x > hi) ? hi : (x < -hi - 1) ? -hi - 1 : x;
endfunction

// Inversion belongs to the source rail, Q is zero in real mode
function automatic iq24_t map_rails(input front_cfg_t c, input iq16_t s);
  logic [15:0] a;
  logic [15:0] b;
  iq24_t       m;
  a = c.invert_i ? ~s.i : s.i;
  b = c.invert_q ? ~s.q : s.q;
  m.i = c.swap_iq ? {b, 8'h00} : {a, 8'h00};
  m.q = c.realmode ? 24'h0 : (c.swap_iq ? {a, 8'h00} : {b, 8'h00});
  return m;
endfunction

// DC offset, then imbalance terms driven by the top 18 bits of I
function automatic iq24_t apply_corrections(input front_cfg_t c, input iq24_t m);
  longint i;
  longint q;
  longint top;
  iq24_t  y;
  i = $signed(m.i);
  q = $signed(m.q);
  i = clamp_signed(i + $signed(c.offset_i), 24);
  q = clamp_signed(q + $signed(c.offset_q), 24);
  top = i >>> 6;
  // Q1.17 times Q1.17 is Q2.34, eleven bits down gives Q1.23
  q = clamp_signed(q + ((top * $signed(c.phase_corr)) >>> 11), 24);
  i = clamp_signed(i + ((top * $signed(c.mag_corr)) >>> 11), 24);
  y.i = i[23:0];
  y.q = q[23:0];
  return y;
endfunction

// Half-up rounding of one rail to sc16 with saturation
function automatic logic [15:0] round_rail(input logic [23:0] v);
  longint r;
  r = $signed(v);
  r = clamp_signed((r + 128) >>> 8, 16);
  return r[15:0];
endfunction

// Expected output for one ADC sample under the given configuration
function automatic iq16_t predict_output(input front_cfg_t c, input iq16_t s);
  iq24_t v;
  iq16_t y;
  v = apply_corrections(c, map_rails(c, s));
  y.i = round_rail(v.i);
  y.q = round_rail(v.q);
  return c.bypass_all ? s : y;
endfunction

`endif

// File: verification/rx_frontend_tb.sv
// Testbench for the receive front end with random samples, reference model and output checks
`timescale 1ns/1ps
`default_nettype none

module rx_frontend_tb
  import rx_frontend_pkg::*;
();

  // Register addresses, same as the DUT defaults
  localparam logic [7:0] ADDR_MAG   = 8'd0;
  localparam logic [7:0] ADDR_PHASE = 8'd1;
  localparam logic [7:0] ADDR_OFS_I = 8'd2;
  localparam logic [7:0] ADDR_OFS_Q = 8'd3;
  localparam logic [7:0] ADDR_MAP   = 8'd4;
  localparam int PIPE_LATENCY = 5;
  localparam int DRAIN_LIMIT  = 200;

  logic        clk        = 1'b0;
  logic        reset      = 1'b1;
  logic        set_stb_i  = 1'b0;
  logic [7:0]  set_addr_i = '0;
  logic [31:0] set_data_i = '0;
  logic        adc_stb_i  = 1'b0;
  iq16_t       adc_i      = '0;
  logic        rx_stb_o;
  iq16_t       rx_o;

  // Settings as last written, plus the outputs still expected and their due cycles
  front_cfg_t  cfg_model = '0;
  iq16_t       exp_q[$];
  int          due_q[$];
  iq16_t       exp_smp;
  int          due_cycle;
  int          cycle     = 0;
  int          in_count  = 0;
  int          out_count = 0;
  logic [31:0] seed_draw;

  `include "rx_frontend_model.svh"

  rx_frontend rx_frontend_inst (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    set_stb_i  = 1'b1;
    set_addr_i = addr;
    set_data_i = data;
    @(negedge clk);
    set_stb_i = 1'b0;
  endtask

  // Program every register, stream samples with random gaps, wait until all came out
  task automatic run_phase(input logic [31:0] map, mag, phase, ofs_i, ofs_q, input int n);
    int waited;
    write_setting(ADDR_MAP, map);
    write_setting(ADDR_MAG, mag);
    write_setting(ADDR_PHASE, phase);
    write_setting(ADDR_OFS_I, ofs_i);
    write_setting(ADDR_OFS_Q, ofs_q);
    // Flag order in the struct differs from the bit order of the mapping word
    cfg_model = {mag[17:0], phase[17:0], ofs_i[23:0], ofs_q[23:0],
                 map[0], map[3], map[2], map[1], map[7]};
    repeat (n) begin
      adc_stb_i = 1'b1;
      adc_i     = $urandom;
      if ($urandom % 4 == 0) begin
        adc_i.i = ($urandom % 2) ? 16'h7fff : 16'h8000;
      end
      exp_q.push_back(predict_output(cfg_model, adc_i));
      due_q.push_back(cycle + (cfg_model.bypass_all ? 1 : PIPE_LATENCY));
      in_count++;
      @(negedge clk);
      adc_stb_i = 1'b0;
      repeat ($urandom % 3) @(negedge clk);
    end
    for (waited = 0; exp_q.size() != 0; waited++) begin
      assert (waited < DRAIN_LIMIT) else fail_run("timed out waiting for outputs to drain");
      @(posedge clk);
    end
    // Samples sent in bypass still run through the pipeline and get discarded
    repeat (8) @(negedge clk);
  endtask

  // Outputs change on the rising edge and are compared on the falling edge
  always @(negedge clk) begin
    if (reset) begin
      assert (rx_stb_o === 1'b0) else fail_run("rx_stb_o was high during reset");
    end else if (rx_stb_o === 1'b1) begin
      assert (exp_q.size() != 0) else
        fail_run("rx_stb_o went high with no sample in flight");
      exp_smp   = exp_q.pop_front();
      due_cycle = due_q.pop_front();
      assert (cycle == due_cycle) else
        fail_run($sformatf("output came at cycle %0d instead of %0d", cycle, due_cycle));
      assert (rx_o.i === exp_smp.i) else
        fail_run($sformatf("[FAIL] rx_o.i got %h expected %h", rx_o.i, exp_smp.i));
      assert (rx_o.q === exp_smp.q) else
        fail_run($sformatf("[FAIL] rx_o.q got %h expected %h", rx_o.q, exp_smp.q));
      out_count++;
    end
  end

  initial begin
    seed_draw = $urandom(32'h4e0b_4645);
    repeat (8) @(negedge clk);
    reset = 1'b0;
    // All settings zero, so every sample comes out unchanged
    run_phase(0, 0, 0, 0, 0, 40);
    repeat (6) begin
      run_phase($urandom % 16, 0, 0, 0, 0, 20);
    end
    // Offsets at both ends of the range, then random ones
    run_phase(0, 0, 0, 32'h007f_ffff, 32'h0080_0000, 20);
    repeat (4) begin
      run_phase(0, 0, 0, $urandom, $urandom, 20);
    end
    repeat (6) begin
      run_phase(0, $urandom, $urandom, $urandom % 4096 - 2048, $urandom % 4096 - 2048, 30);
    end
    // Low offset bytes 0x80 and 0x7f sit on either side of the rounding point
    run_phase(0, 0, 0, 32'h0000_0080, 32'h00ff_ff7f, 30);
    run_phase(32'h80 | ($urandom % 16), $urandom, $urandom, $urandom, $urandom, 30);
    run_phase(0, 0, 0, 0, 0, 10);
    if (out_count == in_count) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_run($sformatf("%0d samples went in but %0d came out", in_count, out_count));
    end
  end

endmodule

`default_nettype wire

// File: verilog/rx_frontend.sv
// Receive front-end top: settings bank, IQ mapper, DC offset, imbalance and output stages
`timescale 1ns/1ps
`default_nettype none

module rx_frontend
  import rx_frontend_pkg::*;
#(
  parameter logic [7:0] SR_MAG_CORRECTION   = 8'd0,
  parameter logic [7:0] SR_PHASE_CORRECTION = 8'd1,
  parameter logic [7:0] SR_OFFSET_I         = 8'd2,
  parameter logic [7:0] SR_OFFSET_Q         = 8'd3,
  parameter logic [7:0] SR_IQ_MAPPING       = 8'd4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        set_stb_i,
  input  logic [7:0]  set_addr_i,
  input  logic [31:0] set_data_i,
  input  logic        adc_stb_i,
  input  iq16_t       adc_i,
  output logic        rx_stb_o,
  output iq16_t       rx_o
);

  front_cfg_t cfg;

  logic  map_stb;
  iq24_t map_smp;
  logic  ofs_stb;
  iq24_t ofs_smp;
  logic  comp_stb;
  iq24_t comp_smp;

  rx_settings #(
    .SR_MAG_CORRECTION   (SR_MAG_CORRECTION),
    .SR_PHASE_CORRECTION (SR_PHASE_CORRECTION),
    .SR_OFFSET_I         (SR_OFFSET_I),
    .SR_OFFSET_Q         (SR_OFFSET_Q),
    .SR_IQ_MAPPING       (SR_IQ_MAPPING)
  ) rx_settings_inst (
    .clk        (clk),
    .reset      (reset),
    .set_stb_i  (set_stb_i),
    .set_addr_i (set_addr_i),
    .set_data_i (set_data_i),
    .cfg_o      (cfg)
  );

  // Input side, one cycle
  iq_mapper iq_mapper_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg_i     (cfg),
    .adc_stb_i (adc_stb_i),
    .adc_i     (adc_i),
    .map_stb_o (map_stb),
    .map_o     (map_smp)
  );

  dc_offset_corr dc_offset_corr_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg_i     (cfg),
    .in_stb_i  (map_stb),
    .in_i      (map_smp),
    .out_stb_o (ofs_stb),
    .out_o     (ofs_smp)
  );

  iq_imbalance_comp iq_imbalance_comp_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg_i     (cfg),
    .in_stb_i  (ofs_stb),
    .in_i      (ofs_smp),
    .out_stb_o (comp_stb),
    .out_o     (comp_smp)
  );

  // Raw ADC sample goes straight to the output stage for bypass
  rx_output_stage rx_output_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg_i     (cfg),
    .in_stb_i  (comp_stb),
    .in_i      (comp_smp),
    .adc_stb_i (adc_stb_i),
    .adc_i     (adc_i),
    .rx_stb_o  (rx_stb_o),
    .rx_o      (rx_o)
  );

endmodule

`default_nettype wire

// File: verilog/rx_output_stage.sv
// Round-half-up to sc16 with saturation and selection of the raw bypass sample
`timescale 1ns/1ps
`default_nettype none

module rx_output_stage
  import rx_frontend_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  front_cfg_t cfg_i,
  input  logic       in_stb_i,
  input  iq24_t      in_i,
  input  logic       adc_stb_i,
  input  iq16_t      adc_i,
  output logic       rx_stb_o,
  output iq16_t      rx_o
);

  localparam int DROP = INT_WIDTH - ADC_WIDTH;

  // Add half an output LSB, drop the low bits, clamp to the sc16 range
  function automatic logic [ADC_WIDTH-1:0] round_sat(input logic signed [INT_WIDTH-1:0] x);
    logic signed [INT_WIDTH:0] biased;
    logic signed [ADC_WIDTH:0] scaled;
    biased = x + (INT_WIDTH+1)'(1 << (DROP - 1));
    scaled = (ADC_WIDTH+1)'(biased >>> DROP);
    if (scaled[ADC_WIDTH] != scaled[ADC_WIDTH-1]) begin
      return scaled[ADC_WIDTH] ? {1'b1, {(ADC_WIDTH-1){1'b0}}} : {1'b0, {(ADC_WIDTH-1){1'b1}}};
    end
    return scaled[ADC_WIDTH-1:0];
  endfunction

  logic  out_load;
  iq16_t out_next;

  // In bypass the pipeline strobes are ignored
  always_comb begin
    if (cfg_i.bypass_all) begin
      out_load = adc_stb_i;
      out_next = adc_i;
    end else begin
      out_load   = in_stb_i;
      out_next.i = round_sat(in_i.i);
      out_next.q = round_sat(in_i.q);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_stb_o <= 1'b0;
    end else begin
      rx_stb_o <= out_load;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      rx_o <= out_next;
    end
  end

endmodule

`default_nettype wire

// File: iq_correction/iq_imbalance_comp.sv
// Two-stage multiply-add-clip for magnitude and phase imbalance correction
`timescale 1ns/1ps
`default_nettype none

module iq_imbalance_comp
  import rx_frontend_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  front_cfg_t cfg_i,
  input  logic       in_stb_i,
  input  iq24_t      in_i,
  output logic       out_stb_o,
  output iq24_t      out_o
);

  // I rail reduced to Q1.17 for the multipliers
  logic signed [COEF_WIDTH-1:0] i_top;

  // Stage one registers
  logic                         s1_stb;
  iq24_t                        s1_smp;
  logic signed [PROD_WIDTH-1:0] s1_prod_i;
  logic signed [PROD_WIDTH-1:0] s1_prod_q;

  // Stage two arithmetic
  logic signed [PROD_WIDTH-1:0] shr_i;
  logic signed [PROD_WIDTH-1:0] shr_q;
  logic signed [PROD_WIDTH-1:0] sum_i;
  logic signed [PROD_WIDTH-1:0] sum_q;

  assign i_top = in_i.i[INT_WIDTH-1 -: COEF_WIDTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_stb    <= 1'b0;
      out_stb_o <= 1'b0;
    end else begin
      s1_stb    <= in_stb_i;
      out_stb_o <= s1_stb;
    end
  end

  // Both corrections are driven by the I rail
  always_ff @(posedge clk) begin
    if (in_stb_i) begin
      s1_smp    <= in_i;
      s1_prod_i <= i_top * cfg_i.mag_corr;
      s1_prod_q <= i_top * cfg_i.phase_corr;
    end
  end

  // Q2.34 down to Q2.23
  assign shr_i = s1_prod_i >>> (2 * (COEF_WIDTH - 1) - (INT_WIDTH - 1));
  assign shr_q = s1_prod_q >>> (2 * (COEF_WIDTH - 1) - (INT_WIDTH - 1));

  assign sum_i = shr_i + s1_smp.i;
  assign sum_q = shr_q + s1_smp.q;

  // Sums fit in SUM_WIDTH bits, the upper product bits only repeat the sign
  always_ff @(posedge clk) begin
    if (s1_stb) begin
      out_o.i <= clip_int(sum_i[SUM_WIDTH-1:0]);
      out_o.q <= clip_int(sum_q[SUM_WIDTH-1:0]);
    end
  end

endmodule

`default_nettype wire

// File: iq_correction/dc_offset_corr.sv
// Per-rail static DC offset addition with saturation to the internal range
`timescale 1ns/1ps
`default_nettype none

module dc_offset_corr
  import rx_frontend_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  front_cfg_t cfg_i,
  input  logic       in_stb_i,
  input  iq24_t      in_i,
  output logic       out_stb_o,
  output iq24_t      out_o
);

  logic signed [SUM_WIDTH-1:0] sum_i;
  logic signed [SUM_WIDTH-1:0] sum_q;

  // Both operands are signed, so they sign-extend into the wider sum
  assign sum_i = in_i.i + cfg_i.offset_i;
  assign sum_q = in_i.q + cfg_i.offset_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_stb_o <= 1'b0;
    end else begin
      out_stb_o <= in_stb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_stb_i) begin
      out_o.i <= clip_int(sum_i);
      out_o.q <= clip_int(sum_q);
    end
  end

endmodule

`default_nettype wire

// File: verilog/iq_mapper.sv
// Registered I/Q swap, rail inversion and real-mode zeroing, widened to 24 bits
`timescale 1ns/1ps
`default_nettype none

module iq_mapper
  import rx_frontend_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  front_cfg_t cfg_i,
  input  logic       adc_stb_i,
  input  iq16_t      adc_i,
  output logic       map_stb_o,
  output iq24_t      map_o
);

  logic [ADC_WIDTH-1:0] inv_i;
  logic [ADC_WIDTH-1:0] inv_q;
  logic [ADC_WIDTH-1:0] sel_i;
  logic [ADC_WIDTH-1:0] sel_q;

  // Inversion follows the source rail, so it is applied before the swap
  always_comb begin
    inv_i = cfg_i.invert_i ? ~adc_i.i : adc_i.i;
    inv_q = cfg_i.invert_q ? ~adc_i.q : adc_i.q;
    sel_i = cfg_i.swap_iq ? inv_q : inv_i;
    sel_q = cfg_i.realmode ? '0 : (cfg_i.swap_iq ? inv_i : inv_q);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      map_stb_o <= 1'b0;
    end else begin
      map_stb_o <= adc_stb_i;
    end
  end

  // Sample goes to the top of the internal word
  always_ff @(posedge clk) begin
    if (adc_stb_i) begin
      map_o.i <= {sel_i, {(INT_WIDTH-ADC_WIDTH){1'b0}}};
      map_o.q <= {sel_q, {(INT_WIDTH-ADC_WIDTH){1'b0}}};
    end
  end

endmodule

`default_nettype wire

// File: verilog/rx_settings.sv
// Settings bus address decode and register bank for the front-end configuration
`timescale 1ns/1ps
`default_nettype none

module rx_settings
  import rx_frontend_pkg::*;
#(
  parameter logic [7:0] SR_MAG_CORRECTION   = 8'd0,
  parameter logic [7:0] SR_PHASE_CORRECTION = 8'd1,
  parameter logic [7:0] SR_OFFSET_I         = 8'd2,
  parameter logic [7:0] SR_OFFSET_Q         = 8'd3,
  parameter logic [7:0] SR_IQ_MAPPING       = 8'd4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        set_stb_i,
  input  logic [7:0]  set_addr_i,
  input  logic [31:0] set_data_i,
  output front_cfg_t  cfg_o
);

  // Each field loads only when its own address is strobed
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_o <= '0;
    end else if (set_stb_i) begin
      if (set_addr_i == SR_MAG_CORRECTION) begin
        cfg_o.mag_corr <= set_data_i[COEF_WIDTH-1:0];
      end
      if (set_addr_i == SR_PHASE_CORRECTION) begin
        cfg_o.phase_corr <= set_data_i[COEF_WIDTH-1:0];
      end
      if (set_addr_i == SR_OFFSET_I) begin
        cfg_o.offset_i <= set_data_i[INT_WIDTH-1:0];
      end
      if (set_addr_i == SR_OFFSET_Q) begin
        cfg_o.offset_q <= set_data_i[INT_WIDTH-1:0];
      end
      // Mapping word, bits 6:4 are reserved
      if (set_addr_i == SR_IQ_MAPPING) begin
        cfg_o.swap_iq    <= set_data_i[0];
        cfg_o.realmode   <= set_data_i[1];
        cfg_o.invert_q   <= set_data_i[2];
        cfg_o.invert_i   <= set_data_i[3];
        cfg_o.bypass_all <= set_data_i[7];
      end
    end
  end

endmodule

`default_nettype wire

// File: common/rx_frontend_pkg.sv
// Widths, I/Q sample structs, front-end configuration struct and the 24-bit clip helper
`default_nettype none

package rx_frontend_pkg;

  // Raw ADC sample width
  localparam int ADC_WIDTH = 16;

  // Internal sample width, Q1.23
  localparam int INT_WIDTH = 24;

  // Correction coefficient width, Q1.17
  localparam int COEF_WIDTH = 18;

  // Full coefficient product, Q2.34
  localparam int PROD_WIDTH = 2 * COEF_WIDTH;

  // Two guard bits above the internal width for sums before clipping
  localparam int SUM_WIDTH = INT_WIDTH + 2;

  // Raw ADC input and sc16 output
  typedef struct packed {
    logic [ADC_WIDTH-1:0] i;
    logic [ADC_WIDTH-1:0] q;
  } iq16_t;

  // Sample pair carried between the internal stages
  typedef struct packed {
    logic signed [INT_WIDTH-1:0] i;
    logic signed [INT_WIDTH-1:0] q;
  } iq24_t;

  // Front-end configuration held by the settings register bank
  typedef struct packed {
    logic signed [COEF_WIDTH-1:0] mag_corr;
    logic signed [COEF_WIDTH-1:0] phase_corr;
    logic signed [INT_WIDTH-1:0]  offset_i;
    logic signed [INT_WIDTH-1:0]  offset_q;
    logic                         swap_iq;
    logic                         invert_i;
    logic                         invert_q;
    logic                         realmode;
    logic                         bypass_all;
  } front_cfg_t;

  // Clip a widened sum back to the signed internal range
  function automatic logic signed [INT_WIDTH-1:0] clip_int(
    input logic signed [SUM_WIDTH-1:0] x
  );
    // The value fits when the guard bits agree with the sign of the result
    if ((x[SUM_WIDTH-1:INT_WIDTH-1] == '0) || (x[SUM_WIDTH-1:INT_WIDTH-1] == '1)) begin
      return x[INT_WIDTH-1:0];
    end else if (x[SUM_WIDTH-1]) begin
      return {1'b1, {(INT_WIDTH-1){1'b0}}};
    end else begin
      return {1'b0, {(INT_WIDTH-1){1'b1}}};
    end
  endfunction

endpackage

`default_nettype wire
